/* design/csr_pkg.sv */
// --------------------------------------------------------------------------
// CSR unit types
// --------------------------------------------------------------------------

`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]       xlen_t;     // Data word
    typedef logic [`CSR_INST_W-1:0]     inst_t;     // Instruction word
    typedef logic [`CSR_REG_ADDR_W-1:0] reg_addr_t; // Integer register index
    typedef logic [`CSR_ADDR_W-1:0]     csr_addr_t; // CSR address

    // Zicsr operations, encoded as funct3
    typedef enum logic [`CSR_FUNCT3_W-1:0] {
        CSR_OP_RW  = `CSR_F3_CSRRW,
        CSR_OP_RS  = `CSR_F3_CSRRS,
        CSR_OP_RC  = `CSR_F3_CSRRC,
        CSR_OP_RWI = `CSR_F3_CSRRWI,
        CSR_OP_RSI = `CSR_F3_CSRRSI,
        CSR_OP_RCI = `CSR_F3_CSRRCI
    } csr_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_COMPUTE = 2'd1,
        SEQ_STORE   = 2'd2
    } seq_state_t;

endpackage

`default_nettype wire

/* design/csr_regfile.sv */
// --------------------------------------------------------------------------
// Machine-mode CSR register file
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_regfile #(
    parameter bit          rv32e   = 1'b0,  // E base instead of I
    parameter int unsigned hart_id = 0
) (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    // Read port
    input  wire csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::xlen_t           rd_data,
    // Instruction write port
    input  wire logic                wr_en,
    input  wire csr_pkg::csr_addr_t  wr_addr,
    input  wire csr_pkg::xlen_t      wr_data,
    // Trap controller loads
    input  wire logic                ctrl_mepc_wr,
    input  wire csr_pkg::xlen_t      ctrl_mepc,
    input  wire logic                ctrl_mstatus_wr,
    input  wire csr_pkg::xlen_t      ctrl_mstatus,
    input  wire logic                ctrl_mcause_wr,
    input  wire csr_pkg::xlen_t      ctrl_mcause,
    // Published registers
    output csr_pkg::xlen_t           mtvec,
    output csr_pkg::xlen_t           mepc,
    output csr_pkg::xlen_t           mstatus
);

    import csr_pkg::*;

    localparam int    misa_e_bit  = 4;
    localparam int    misa_i_bit  = 8;
    localparam xlen_t misa_ext    = rv32e ? (xlen_t'(1) << misa_e_bit)
                                          : (xlen_t'(1) << misa_i_bit);
    localparam xlen_t misa_val    = `CSR_MISA_MXL32 | misa_ext;
    localparam xlen_t mhartid_val = xlen_t'(hart_id);

    xlen_t mscratch;
    xlen_t mcause;
    xlen_t mtval;

    // Instruction write hits
    logic  wr_mstatus;
    logic  wr_mtvec;
    logic  wr_mscratch;
    logic  wr_mepc;
    logic  wr_mcause;
    logic  wr_mtval;

    // Trap load wins over instruction write
    xlen_t mstatus_in;
    xlen_t mepc_in;
    xlen_t mcause_in;

    // ----------------------------------------------------------------------
    // Write decode
    // ----------------------------------------------------------------------

    assign wr_mstatus  = wr_en && (wr_addr == `CSR_MSTATUS_ADDR);
    assign wr_mtvec    = wr_en && (wr_addr == `CSR_MTVEC_ADDR);
    assign wr_mscratch = wr_en && (wr_addr == `CSR_MSCRATCH_ADDR);
    assign wr_mepc     = wr_en && (wr_addr == `CSR_MEPC_ADDR);
    assign wr_mcause   = wr_en && (wr_addr == `CSR_MCAUSE_ADDR);
    assign wr_mtval    = wr_en && (wr_addr == `CSR_MTVAL_ADDR);

    assign mstatus_in = ctrl_mstatus_wr ? ctrl_mstatus : wr_data;
    assign mepc_in    = ctrl_mepc_wr    ? ctrl_mepc    : wr_data;
    assign mcause_in  = ctrl_mcause_wr  ? ctrl_mcause  : wr_data;

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            // Reserved mstatus bits read as zero
            if (ctrl_mstatus_wr || wr_mstatus) begin
                mstatus <= mstatus_in & `CSR_MSTATUS_MASK;
            end
            if (wr_mtvec) begin
                mtvec <= wr_data;
            end
            if (wr_mscratch) begin
                mscratch <= wr_data;
            end
            // IALIGN=32 only
            if (ctrl_mepc_wr || wr_mepc) begin
                mepc <= {mepc_in[`CSR_XLEN-1:2], 2'b00};
            end
            if (ctrl_mcause_wr || wr_mcause) begin
                mcause <= mcause_in;
            end
            if (wr_mtval) begin
                mtval <= wr_data;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------

    always_comb begin
        case (rd_addr)
            `CSR_MSTATUS_ADDR:  rd_data = mstatus;
            `CSR_MISA_ADDR:     rd_data = misa_val;     // Read-only here
            `CSR_MTVEC_ADDR:    rd_data = mtvec;
            `CSR_MSCRATCH_ADDR: rd_data = mscratch;
            `CSR_MEPC_ADDR:     rd_data = mepc;
            `CSR_MCAUSE_ADDR:   rd_data = mcause;
            `CSR_MTVAL_ADDR:    rd_data = mtval;
            `CSR_MHARTID_ADDR:  rd_data = mhartid_val;
            default:            rd_data = '0;           // Unimplemented
        endcase
    end

endmodule

`default_nettype wire

/* design/csr_sequencer.sv */
// --------------------------------------------------------------------------
// CSR instruction sequencer
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_sequencer (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    // Instruction handshake
    input  wire logic                valid,
    output logic                     ready,
    input  wire csr_pkg::inst_t      instbus,
    // Integer register file
    output csr_pkg::reg_addr_t       rs1_addr,
    input  wire csr_pkg::xlen_t      rs1_val,
    output logic                     rd_wr_en,
    output csr_pkg::reg_addr_t       rd_wr_addr,
    output csr_pkg::xlen_t           rd_wr_val,
    // CSR read port
    output csr_pkg::csr_addr_t       rd_addr,
    input  wire csr_pkg::xlen_t      rd_data,
    // CSR write port
    output logic                     wr_en,
    output csr_pkg::csr_addr_t       wr_addr,
    output csr_pkg::xlen_t           wr_data
);

    import csr_pkg::*;

    seq_state_t state;
    logic       accept;       // Handshake completes this edge
    csr_op_t    op_dec;       // funct3 of the incoming instruction
    csr_op_t    op_r;
    csr_addr_t  csr_r;
    reg_addr_t  src_idx_r;    // rs1 index or zimm
    xlen_t      rs1_val_r;
    xlen_t      old_r;        // CSR value before the write
    xlen_t      src_val;
    xlen_t      new_val;
    logic       write_csr;

    // ----------------------------------------------------------------------
    // Instruction decode
    // ----------------------------------------------------------------------

    assign rs1_addr = instbus[`CSR_RS1_LSB +: `CSR_REG_ADDR_W];
    assign rd_addr  = instbus[`CSR_ADDR_LSB +: `CSR_ADDR_W];   // Old value lookup
    assign op_dec   = csr_op_t'(instbus[`CSR_FUNCT3_LSB +: `CSR_FUNCT3_W]);
    assign accept   = (state == SEQ_IDLE) && valid && ready;
    assign wr_addr  = csr_r;

    // Immediate forms take zimm zero-extended
    assign src_val = (op_r inside {CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI}) ?
                     xlen_t'(src_idx_r) : rs1_val_r;

    // New CSR value, write suppressed for set/clear from x0 or zimm 0
    always_comb begin
        new_val   = old_r;
        write_csr = 1'b0;
        case (op_r)
            CSR_OP_RW, CSR_OP_RWI: begin
                new_val   = src_val;                 // Swap
                write_csr = 1'b1;
            end
            CSR_OP_RS, CSR_OP_RSI: begin
                new_val   = old_r | src_val;         // Set bits
                write_csr = (src_idx_r != '0);
            end
            CSR_OP_RC, CSR_OP_RCI: begin
                new_val   = old_r & ~src_val;        // Clear bits where mask is 1
                write_csr = (src_idx_r != '0);
            end
            default: write_csr = 1'b0;               // Not a Zicsr op
        endcase
    end

    // ----------------------------------------------------------------------
    // Accept / compute / store machine
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= SEQ_IDLE;
            ready    <= 1'b0;
            rd_wr_en <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        ready <= 1'b0;
                        state <= SEQ_COMPUTE;
                    end else begin
                        ready <= 1'b1;          // Rises one cycle out of reset
                    end
                end
                SEQ_COMPUTE: begin
                    rd_wr_en <= 1'b1;           // Old value to rd
                    wr_en    <= write_csr;
                    state    <= SEQ_STORE;
                end
                SEQ_STORE: begin
                    // CSR write commits on this edge
                    rd_wr_en <= 1'b0;
                    wr_en    <= 1'b0;
                    ready    <= 1'b1;
                    state    <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Operand capture and results
    always_ff @(posedge aclk) begin
        if (accept) begin
            op_r       <= op_dec;
            csr_r      <= rd_addr;
            src_idx_r  <= rs1_addr;
            rs1_val_r  <= rs1_val;
            old_r      <= rd_data;
            rd_wr_addr <= instbus[`CSR_RD_LSB +: `CSR_REG_ADDR_W];
        end
        if (state == SEQ_COMPUTE) begin
            rd_wr_val <= old_r;
            wr_data   <= new_val;
        end
    end

endmodule

`default_nettype wire

/* design/csr_unit.sv */
// --------------------------------------------------------------------------
// Machine-mode CSR execution unit
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter bit          rv32e   = 1'b0,
    parameter int unsigned hart_id = 0
) (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    // Instruction handshake
    input  wire logic                valid,
    output logic                     ready,
    input  wire csr_pkg::inst_t      instbus,
    // Integer register file
    output csr_pkg::reg_addr_t       rs1_addr,
    input  wire csr_pkg::xlen_t      rs1_val,
    output logic                     rd_wr_en,
    output csr_pkg::reg_addr_t       rd_wr_addr,
    output csr_pkg::xlen_t           rd_wr_val,
    // Trap controller
    input  wire logic                ctrl_mepc_wr,
    input  wire csr_pkg::xlen_t      ctrl_mepc,
    input  wire logic                ctrl_mstatus_wr,
    input  wire csr_pkg::xlen_t      ctrl_mstatus,
    input  wire logic                ctrl_mcause_wr,
    input  wire csr_pkg::xlen_t      ctrl_mcause,
    // Published CSRs
    output csr_pkg::xlen_t           mtvec,
    output csr_pkg::xlen_t           mepc,
    output csr_pkg::xlen_t           mstatus
);

    import csr_pkg::*;

    // Sequencer to register file
    csr_addr_t rd_addr;
    xlen_t     rd_data;
    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    csr_sequencer csr_sequencer_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    csr_regfile #(
        .rv32e   (rv32e),
        .hart_id (hart_id)
    ) csr_regfile_i (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus         (mstatus)
    );

endmodule

`default_nettype wire

/* include/csr_consts.svh */
// --------------------------------------------------------------------------
// CSR unit constants
// --------------------------------------------------------------------------

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Widths
`define CSR_XLEN          32
`define CSR_INST_W        32
`define CSR_REG_ADDR_W    5
`define CSR_ADDR_W        12
`define CSR_FUNCT3_W      3

// Instruction field offsets
`define CSR_RD_LSB        7
`define CSR_FUNCT3_LSB    12
// Shared by rs1 index and zimm
`define CSR_RS1_LSB       15
`define CSR_ADDR_LSB      20

// Zicsr funct3 codes
`define CSR_F3_CSRRW      3'b001
`define CSR_F3_CSRRS      3'b010
`define CSR_F3_CSRRC      3'b011
`define CSR_F3_CSRRWI     3'b101
`define CSR_F3_CSRRSI     3'b110
`define CSR_F3_CSRRCI     3'b111

// Machine CSR addresses
`define CSR_MSTATUS_ADDR  12'h300
`define CSR_MISA_ADDR     12'h301
`define CSR_MTVEC_ADDR    12'h305
`define CSR_MSCRATCH_ADDR 12'h340
`define CSR_MEPC_ADDR     12'h341
`define CSR_MCAUSE_ADDR   12'h342
`define CSR_MTVAL_ADDR    12'h343
`define CSR_MHARTID_ADDR  12'hF14

// Writable mstatus fields
// SD, TSR..MPP, SPP/MPIE, SPIE/UPIE/MIE, SIE/UIE
`define CSR_MSTATUS_MASK  32'h807F_F9BB

// MXL = 1 for a 32-bit hart
`define CSR_MISA_MXL32    32'h4000_0000

`endif

/* run.sh */
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_unit_tb -f tb.f -o csr_unit_sim \
    && ./obj_dir/csr_unit_sim | tee /dev/stderr | grep -F "Finished with no errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb.f */
+incdir+include
design/csr_pkg.sv
design/csr_sequencer.sv
design/csr_regfile.sv
design/csr_unit.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

/* verification/csr_unit_chk.sv */
// --------------------------------------------------------------------------
// CSR unit protocol checks
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module csr_unit_chk (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    input  wire logic                valid,
    input  wire logic                ready,
    input  wire logic                rd_wr_en,
    input  wire csr_pkg::xlen_t      mepc
);

    // rd write is a single-cycle pulse
    rd_pulse_one_cycle: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en |=> !rd_wr_en
    ) else $error("rd_wr_en high for more than one cycle");

    // Pulse ends exactly two edges after the accept edge
    rd_fall_after_accept: assert property (
        @(posedge aclk) disable iff (!aresetn) $fell(rd_wr_en) |-> $past(valid && ready, 3)
    ) else $error("rd_wr_en fell without an accept two edges earlier");

    accept_gives_rd_fall: assert property (
        @(posedge aclk) disable iff (!aresetn) $past(valid && ready, 3) |-> $fell(rd_wr_en)
    ) else $error("accepted instruction gave no rd_wr_en pulse of the right timing");

    // Busy while the result goes out
    no_ready_during_rd: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en |-> !ready
    ) else $error("ready high while rd_wr_en is high");

    mepc_aligned: assert property (
        @(posedge aclk) disable iff (!aresetn) mepc[1:0] == 2'b00
    ) else $error("mepc bits 1:0 not zero");

endmodule

`default_nettype wire

/* verification/csr_unit_tb.sv */
// --------------------------------------------------------------------------
// CSR unit testbench
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int unsigned hart_num       = 5;
    localparam int          timeout_cycles = 20;

    // One table row for an instruction or a trap load
    typedef struct packed {
        logic      trap;
        csr_op_t   op;
        csr_addr_t addr;
        reg_addr_t rd;
        reg_addr_t src;          // rs1 index or zimm
        xlen_t     val;          // rs1 value or trap data
        xlen_t     exp_rd;       // Old CSR value
        xlen_t     exp_mtvec;
        xlen_t     exp_mepc;
        xlen_t     exp_mstatus;
    } entry_t;

    logic      aclk;
    logic      aresetn;
    logic      valid;
    logic      ready;
    inst_t     instbus;
    reg_addr_t rs1_addr;
    xlen_t     rs1_val;
    logic      rd_wr_en;
    reg_addr_t rd_wr_addr;
    xlen_t     rd_wr_val;
    logic      ctrl_mepc_wr;
    xlen_t     ctrl_mepc;
    logic      ctrl_mstatus_wr;
    xlen_t     ctrl_mstatus;
    logic      ctrl_mcause_wr;
    xlen_t     ctrl_mcause;
    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mstatus;

    entry_t tbl[$];
    integer seed      = 17;
    int     pulse_cnt = 0;      // rd_wr_en cycles seen
    int     inst_cnt  = 0;      // Instructions in the table

    // Reference CSR state
    xlen_t  m_mstatus;
    xlen_t  m_mtvec;
    xlen_t  m_mscratch;
    xlen_t  m_mepc;
    xlen_t  m_mcause;
    xlen_t  m_mtval;

    csr_unit #(
        .rv32e   (1'b0),
        .hart_id (hart_num)
    ) csr_unit_i (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .valid           (valid),
        .ready           (ready),
        .instbus         (instbus),
        .rs1_addr        (rs1_addr),
        .rs1_val         (rs1_val),
        .rd_wr_en        (rd_wr_en),
        .rd_wr_addr      (rd_wr_addr),
        .rd_wr_val       (rd_wr_val),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus         (mstatus)
    );

    bind csr_unit csr_unit_chk csr_unit_chk_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .valid    (valid),
        .ready    (ready),
        .rd_wr_en (rd_wr_en),
        .mepc     (mepc)
    );

    always #10 aclk = ~aclk;   // 20 ns period

    always @(negedge aclk) begin
        if (aresetn && rd_wr_en) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Reporting and compares
    // ----------------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_reg_addr(input string what, input reg_addr_t got,
                                  input reg_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_ports(input entry_t e);
        check_word("mtvec", mtvec, e.exp_mtvec);
        check_word("mepc", mepc, e.exp_mepc);
        check_word("mstatus", mstatus, e.exp_mstatus);
    endtask

    // Both waits sample on the falling edge away from register updates
    task automatic wait_ready;
        int n;
        n = 0;
        @(negedge aclk);
        while (ready !== 1'b1) begin
            n++;
            if (n > timeout_cycles) begin
                fail_run("Timeout: ready did not go high");
            end
            @(negedge aclk);
        end
    endtask

    task automatic wait_rd_wr_en;
        int n;
        n = 0;
        @(negedge aclk);
        while (rd_wr_en !== 1'b1) begin
            n++;
            if (n > timeout_cycles) begin
                fail_run("Timeout: no rd_wr_en pulse after the instruction");
            end
            @(negedge aclk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model of the CSR rules
    // ----------------------------------------------------------------------

    function automatic xlen_t model_read(input csr_addr_t a);
        case (a)
            `CSR_MSTATUS_ADDR:  return m_mstatus;
            `CSR_MISA_ADDR:     return `CSR_MISA_MXL32 | (xlen_t'(1) << 8);  // MXL plus I
            `CSR_MTVEC_ADDR:    return m_mtvec;
            `CSR_MSCRATCH_ADDR: return m_mscratch;
            `CSR_MEPC_ADDR:     return m_mepc;
            `CSR_MCAUSE_ADDR:   return m_mcause;
            `CSR_MTVAL_ADDR:    return m_mtval;
            `CSR_MHARTID_ADDR:  return xlen_t'(hart_num);
            default:            return '0;
        endcase
    endfunction

    task automatic model_write(input csr_addr_t a, input xlen_t v);
        case (a)
            `CSR_MSTATUS_ADDR:  m_mstatus  = v & `CSR_MSTATUS_MASK;
            `CSR_MTVEC_ADDR:    m_mtvec    = v;
            `CSR_MSCRATCH_ADDR: m_mscratch = v;
            `CSR_MEPC_ADDR:     m_mepc     = v & ~xlen_t'(3);   // Word aligned
            `CSR_MCAUSE_ADDR:   m_mcause   = v;
            `CSR_MTVAL_ADDR:    m_mtval    = v;
            default: ;                                          // Read-only or absent
        endcase
    endtask

    task automatic add_inst(input csr_op_t op, input csr_addr_t addr, input reg_addr_t rd,
                            input reg_addr_t src, input xlen_t val);
        entry_t e;
        e      = '0;
        e.op   = op;
        e.addr = addr;
        e.rd   = rd;
        e.src  = src;
        e.val  = val;
        tbl.push_back(e);
    endtask

    task automatic add_trap(input csr_addr_t addr, input xlen_t val);
        entry_t e;
        e      = '0;
        e.trap = 1'b1;
        e.op   = CSR_OP_RW;
        e.addr = addr;
        e.val  = val;
        tbl.push_back(e);
    endtask

    task automatic load_table;
        add_inst(CSR_OP_RW,  `CSR_MTVEC_ADDR,    5'd1,  5'd2,  32'h8000_0100);
        add_inst(CSR_OP_RWI, `CSR_MTVEC_ADDR,    5'd3,  5'd5,  32'h0);
        add_inst(CSR_OP_RW,  `CSR_MSCRATCH_ADDR, 5'd4,  5'd6,  32'hDEAD_BEEF);
        add_inst(CSR_OP_RWI, `CSR_MTVAL_ADDR,    5'd6,  5'd31, 32'h0);
        add_inst(CSR_OP_RS,  `CSR_MTVAL_ADDR,    5'd7,  5'd0,  32'hFFFF_FFFF);  // x0 source
        add_inst(CSR_OP_RC,  `CSR_MSCRATCH_ADDR, 5'd8,  5'd9,  32'h0000_FFFF);
        add_inst(CSR_OP_RSI, `CSR_MSCRATCH_ADDR, 5'd9,  5'd17, 32'h0);
        add_inst(CSR_OP_RCI, `CSR_MSCRATCH_ADDR, 5'd10, 5'd1,  32'h0);
        add_inst(CSR_OP_RCI, `CSR_MSCRATCH_ADDR, 5'd11, 5'd0,  32'h0);          // zimm 0
        add_inst(CSR_OP_RC,  `CSR_MTVEC_ADDR,    5'd12, 5'd0,  32'hFFFF_FFFF);
        add_inst(CSR_OP_RSI, `CSR_MTVEC_ADDR,    5'd13, 5'd0,  32'h0);
        add_inst(CSR_OP_RS,  `CSR_MSCRATCH_ADDR, 5'd14, 5'd0,  32'h0);
        add_inst(CSR_OP_RW,  `CSR_MSTATUS_ADDR,  5'd15, 5'd16, 32'hFFFF_FFFF);
        add_inst(CSR_OP_RC,  `CSR_MSTATUS_ADDR,  5'd16, 5'd17, 32'h0000_0088);
        add_inst(CSR_OP_RW,  `CSR_MEPC_ADDR,     5'd17, 5'd18, 32'h1234_5677);
        add_inst(CSR_OP_RW,  `CSR_MISA_ADDR,     5'd18, 5'd19, 32'h0);
        add_inst(CSR_OP_RS,  `CSR_MISA_ADDR,     5'd19, 5'd0,  32'h0);
        add_inst(CSR_OP_RS,  `CSR_MHARTID_ADDR,  5'd20, 5'd0,  32'h0);
        add_inst(CSR_OP_RW,  12'h7C0,            5'd21, 5'd22, 32'hAAAA_5555);  // Unknown
        add_inst(CSR_OP_RS,  12'h7C0,            5'd22, 5'd0,  32'h0);
        add_trap(`CSR_MEPC_ADDR,    32'h0000_2003);
        add_trap(`CSR_MSTATUS_ADDR, 32'hFFFF_0000);
        add_trap(`CSR_MCAUSE_ADDR,  32'h8000_000B);
        add_inst(CSR_OP_RS,  `CSR_MCAUSE_ADDR,   5'd23, 5'd0,  32'h0);
        add_inst(CSR_OP_RWI, `CSR_MCAUSE_ADDR,   5'd24, 5'd3,  32'h0);
        add_inst(CSR_OP_RS,  `CSR_MCAUSE_ADDR,   5'd25, 5'd0,  32'h0);
        add_inst(CSR_OP_RS,  `CSR_MTVAL_ADDR,    5'd26, 5'd0,  32'h0);
    endtask

    // Walk the table through the model to fill in expected values
    task automatic build_expected;
        entry_t e;
        xlen_t  src;
        xlen_t  old;
        m_mstatus  = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (e.trap) begin
                model_write(e.addr, e.val);
            end else begin
                old = model_read(e.addr);
                src = (e.op inside {CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI}) ?
                      xlen_t'(e.src) : e.val;
                case (e.op)
                    CSR_OP_RW, CSR_OP_RWI: model_write(e.addr, src);
                    CSR_OP_RS, CSR_OP_RSI: if (e.src != '0) model_write(e.addr, old | src);
                    default:               if (e.src != '0) model_write(e.addr, old & ~src);
                endcase
                e.exp_rd = old;
                inst_cnt++;
            end
            e.exp_mtvec   = m_mtvec;
            e.exp_mepc    = m_mepc;
            e.exp_mstatus = m_mstatus;
            tbl[i]        = e;
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    function automatic inst_t encode(input entry_t e);
        return {e.addr, e.src, e.op, e.rd, 7'b1110011};   // SYSTEM opcode
    endfunction

    task automatic run_inst(input entry_t e, input bit hold);
        valid   = 1'b1;
        instbus = encode(e);
        rs1_val = e.val;
        wait_ready;
        check_reg_addr("rs1_addr", rs1_addr, e.src);
        @(posedge aclk);                // Accept edge
        #1;
        if (!hold) begin
            valid   = 1'b0;             // Junk on the bus while busy
            instbus = $random(seed);
            rs1_val = $random(seed);
        end
        wait_rd_wr_en;
        check_word("rd_wr_val", rd_wr_val, e.exp_rd);
        check_reg_addr("rd_wr_addr", rd_wr_addr, e.rd);
        @(posedge aclk);                // CSR write commits
        #1;
        valid = 1'b0;                   // Drop before ready is seen again
        @(negedge aclk);
        check_ports(e);
    endtask

    task automatic run_trap(input entry_t e);
        case (e.addr)
            `CSR_MEPC_ADDR: begin
                ctrl_mepc_wr = 1'b1;
                ctrl_mepc    = e.val;
            end
            `CSR_MSTATUS_ADDR: begin
                ctrl_mstatus_wr = 1'b1;
                ctrl_mstatus    = e.val;
            end
            default: begin
                ctrl_mcause_wr = 1'b1;
                ctrl_mcause    = e.val;
            end
        endcase
        @(posedge aclk);                // Load lands here
        #1;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mcause_wr  = 1'b0;
        @(negedge aclk);
        check_ports(e);
    endtask

    initial begin
        int gap;
        bit hold;
        aclk            = 1'b0;
        aresetn         = 1'b0;
        valid           = 1'b0;
        instbus         = '0;
        rs1_val         = '0;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mepc       = '0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mstatus    = '0;
        ctrl_mcause_wr  = 1'b0;
        ctrl_mcause     = '0;
        load_table;
        build_expected;

        // Reset for 5 cycles
        repeat (5) begin
            @(negedge aclk);
            check_word("ready in reset", xlen_t'(ready), '0);
            check_word("rd_wr_en in reset", xlen_t'(rd_wr_en), '0);
        end
        @(posedge aclk);
        #1;
        aresetn = 1'b1;
        check_word("mtvec after reset", mtvec, '0);
        check_word("mepc after reset", mepc, '0);
        check_word("mstatus after reset", mstatus, '0);
        wait_ready;
        @(posedge aclk);
        #1;

        for (int i = 0; i < tbl.size(); i++) begin
            hold = ((i % 3) == 0) || (($random(seed) & 1) != 0);  // valid held while busy
            if (tbl[i].trap) begin
                run_trap(tbl[i]);
            end else begin
                run_inst(tbl[i], hold);
            end
            gap = $random(seed) & 3;
            repeat (gap + 1) @(posedge aclk);
            #1;
        end

        if (pulse_cnt == inst_cnt) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run($sformatf("Mismatch at %0t ns: %0d rd_wr_en pulses for %0d instructions",
                               $time, pulse_cnt, inst_cnt));
        end
    end

endmodule

`default_nettype wire
